// File: hw/core_pkg.sv
/*
  Core side types
  Operand bundle from issue, exception record for writeback,
  privilege levels and the exception causes used here
*/
`include "xif_settings.svh"

package core_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // Causes fit in the 6-bit exccode of a result
  typedef enum logic [5:0] {
    CAUSE_ILLEGAL_INSTR = 6'd2,
    CAUSE_XBOUND        = 6'd24
  } exc_cause_e;

  // Operands as delivered by the issue stage
  typedef struct packed {
    logic [`XIF_ID_BITS-1:0] trans_id;
    logic [`XIF_XLEN-1:0]    operand_a;
    logic [`XIF_XLEN-1:0]    operand_b;
    logic [`XIF_XLEN-1:0]    imm;
  } fu_data_t;

  typedef struct packed {
    logic                 valid;
    logic [`XIF_XLEN-1:0] cause;
    logic [`XIF_XLEN-1:0] tval;
  } exception_t;

endpackage

// File: hw/xif_alu.sv
/*
  Coprocessor execute stage
  Computes the custom operations from stage 1 and holds a result
  record in stage 2 until the core takes it
*/
`timescale 1ns/1ps
`include "xif_settings.svh"

module xif_alu
  import xif_pkg::*;
  import core_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  xif_exec_t   exec_i,
  input  logic        exec_valid_i,
  input  logic        result_ready_i,
  output logic        alu_ready_o,
  output logic        result_valid_o,
  output xif_result_t result_o
);

  logic [`XIF_XLEN-1:0] rs1;
  logic [`XIF_XLEN-1:0] rs2;
  logic [`XIF_XLEN-1:0] rs3;
  xif_result_t          res_d;
  xif_result_t          res_q;
  logic                 valid_q;

  assign rs1 = exec_i.rs[0];
  assign rs2 = exec_i.rs[1];
  assign rs3 = exec_i.rs[2];

  always_comb begin
    res_d         = '0;
    res_d.id      = exec_i.id;
    res_d.we      = 1'b1;
    case (exec_i.op)
      OP_XADD3: begin
        res_d.data = rs1 + rs2 + rs3;
      end
      OP_XMULLO: begin
        // Low half of the product only
        res_d.data = rs1 * rs2;
      end
      OP_XMAXU: begin
        res_d.data = (rs1 > rs2) ? rs1 : rs2;
      end
      OP_XBOUND: begin
        if (rs1 > rs2) begin
          res_d.we      = 1'b0;
          res_d.exc     = 1'b1;
          res_d.exccode = CAUSE_XBOUND;
        end else begin
          res_d.data = rs1;
        end
      end
      default: begin
        res_d.we = 1'b0;
      end
    endcase
  end

  // Stage 2 advances when empty or when its record is taken
  assign alu_ready_o = ~valid_q | result_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (alu_ready_o) begin
      valid_q <= exec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_ready_o && exec_valid_i) begin
      res_q <= res_d;
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = res_q;

endmodule

// File: hw/xif_decoder.sv
/*
  Coprocessor front end
  Decodes custom-0 instructions, decides accept or reject and
  registers accepted work as ALU stage 1
*/
`timescale 1ns/1ps

module xif_decoder
  import xif_pkg::*;
  import core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  xif_req_t  xif_req_i,
  input  logic      alu_ready_i,
  output logic      issue_ready_o,
  output logic      issue_accept_o,
  output xif_exec_t exec_o,
  output logic      exec_valid_o
);

  xif_op_e   op;
  logic      accept;
  logic      issue_hs;
  xif_exec_t exec_q;
  logic      exec_valid_q;

  always_comb begin
    op = OP_NONE;
    if (xif_req_i.issue_req.instr[6:0] == OPCODE_CUSTOM0 &&
        xif_req_i.issue_req.instr[31:25] == 7'b0) begin
      case (xif_req_i.issue_req.instr[14:12])
        F3_XADD3:  op = OP_XADD3;
        F3_XMULLO: op = OP_XMULLO;
        F3_XMAXU:  op = OP_XMAXU;
        F3_XBOUND: op = OP_XBOUND;
        default:   op = OP_NONE;
      endcase
    end
  end

  // Multiply is privileged, and all operands must be present
  assign accept = (op != OP_NONE) &&
                  !(op == OP_XMULLO && xif_req_i.issue_req.mode == PRIV_U) &&
                  (&xif_req_i.issue_req.rs_valid);

  assign issue_ready_o  = alu_ready_i;
  assign issue_accept_o = accept;
  assign issue_hs       = xif_req_i.issue_valid & alu_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exec_valid_q <= 1'b0;
    end else if (alu_ready_i) begin
      exec_valid_q <= issue_hs & accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_hs && accept) begin
      exec_q.op <= op;
      exec_q.id <= xif_req_i.issue_req.id;
      exec_q.rs <= xif_req_i.issue_req.rs;
    end
  end

  assign exec_o       = exec_q;
  assign exec_valid_o = exec_valid_q;

endmodule

// File: hw/xif_fu.sv
/*
  Core functional unit for offloaded instructions
  Sends issue and commit to the coprocessor, turns its results into
  writebacks and reports rejected issues as illegal instructions
*/
`timescale 1ns/1ps
`include "xif_settings.svh"

module xif_fu
  import xif_pkg::*;
  import core_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  fu_data_t                fu_data_i,
  input  priv_lvl_e               priv_lvl_i,
  // From issue
  input  logic                    x_valid_i,
  output logic                    x_ready_o,
  input  logic [31:0]             x_off_instr_i,
  // To writeback
  output logic [`XIF_ID_BITS-1:0] x_trans_id_o,
  output logic [`XIF_XLEN-1:0]    x_result_o,
  output logic                    x_we_o,
  output logic                    x_valid_o,
  output exception_t              x_exception_o,
  // To and from the coprocessor
  output xif_req_t                xif_req_o,
  input  xif_resp_t               xif_resp_i
);

  logic                    illegal_q;
  logic                    illegal_d;
  logic [`XIF_ID_BITS-1:0] illegal_id_q;
  logic [31:0]             illegal_instr_q;
  logic                    reject_hs;
  logic                    report_pending;
  logic                    show_illegal;
  logic [`XIF_ID_BITS-1:0] report_id;
  logic [31:0]             report_instr;

  // Request side, no new issue goes out while a report waits
  always_comb begin
    xif_req_o                    = '0;
    xif_req_o.result_ready       = 1'b1;
    xif_req_o.issue_valid        = x_valid_i & ~illegal_q;
    xif_req_o.issue_req.instr    = x_off_instr_i;
    xif_req_o.issue_req.mode     = priv_lvl_i;
    xif_req_o.issue_req.id       = fu_data_i.trans_id;
    xif_req_o.issue_req.rs[0]    = fu_data_i.operand_a;
    xif_req_o.issue_req.rs[1]    = fu_data_i.operand_b;
    xif_req_o.issue_req.rs[2]    = fu_data_i.imm;
    xif_req_o.issue_req.rs_valid = '1;
    // Commit goes with the issue and is never killed
    xif_req_o.commit_valid       = xif_req_o.issue_valid;
    xif_req_o.commit_id          = fu_data_i.trans_id;
  end

  assign x_ready_o = xif_resp_i.issue_ready & ~illegal_q;

  assign reject_hs = xif_req_o.issue_valid & xif_resp_i.issue_ready &
                     ~xif_resp_i.issue_accept;

  // A pending report blocks issue, so the two sources never coincide
  assign report_pending = illegal_q | reject_hs;
  assign report_id      = illegal_q ? illegal_id_q : fu_data_i.trans_id;
  assign report_instr   = illegal_q ? illegal_instr_q : x_off_instr_i;

  // Coprocessor results take the writeback port first
  assign show_illegal = report_pending & ~xif_resp_i.result_valid;
  assign illegal_d    = report_pending & xif_resp_i.result_valid;

  always_comb begin
    x_valid_o           = 1'b0;
    x_trans_id_o        = '0;
    x_result_o          = '0;
    x_we_o              = 1'b0;
    x_exception_o       = '0;
    if (xif_resp_i.result_valid) begin
      x_valid_o           = 1'b1;
      x_trans_id_o        = xif_resp_i.result.id;
      x_result_o          = xif_resp_i.result.data;
      x_we_o              = xif_resp_i.result.we;
      x_exception_o.valid = xif_resp_i.result.exc;
      x_exception_o.cause = {{(`XIF_XLEN-6){1'b0}}, xif_resp_i.result.exccode};
    end else if (show_illegal) begin
      x_valid_o           = 1'b1;
      x_trans_id_o        = report_id;
      x_exception_o.valid = 1'b1;
      x_exception_o.cause = {{(`XIF_XLEN-6){1'b0}}, CAUSE_ILLEGAL_INSTR};
      x_exception_o.tval  = report_instr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= illegal_d;
    end
  end

  // Report payload, captured on the rejecting handshake
  always_ff @(posedge clk_i) begin
    if (reject_hs) begin
      illegal_id_q    <= fu_data_i.trans_id;
      illegal_instr_q <= x_off_instr_i;
    end
  end

endmodule

// File: hw/xif_pkg.sv
/*
  Extension interface types
  Request and response bundles between core and coprocessor,
  custom-0 encodings and the coprocessor operation enum
*/
`include "xif_settings.svh"

package xif_pkg;

  // Major opcode of the custom-0 space
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // funct3 selects the operation when funct7 is zero
  typedef enum logic [2:0] {
    F3_XADD3  = 3'b000,
    F3_XMULLO = 3'b001,
    F3_XMAXU  = 3'b010,
    F3_XBOUND = 3'b011
  } xif_funct3_e;

  typedef enum logic [2:0] {
    OP_XADD3,
    OP_XMULLO,
    OP_XMAXU,
    OP_XBOUND,
    OP_NONE
  } xif_op_e;

  typedef logic [`XIF_NUM_RS-1:0][`XIF_XLEN-1:0] xif_rs_t;

  typedef struct packed {
    logic [31:0]             instr;
    logic [1:0]              mode;
    logic [`XIF_ID_BITS-1:0] id;
    xif_rs_t                 rs;
    logic [`XIF_NUM_RS-1:0]  rs_valid;
  } xif_issue_req_t;

  // Driven by the core
  typedef struct packed {
    logic                    issue_valid;
    xif_issue_req_t          issue_req;
    logic                    commit_valid;
    logic [`XIF_ID_BITS-1:0] commit_id;
    logic                    result_ready;
  } xif_req_t;

  typedef struct packed {
    logic [`XIF_ID_BITS-1:0] id;
    logic [`XIF_XLEN-1:0]    data;
    logic                    we;
    logic                    exc;
    logic [5:0]              exccode;
  } xif_result_t;

  // Driven by the coprocessor
  typedef struct packed {
    logic        issue_ready;
    logic        issue_accept;
    logic        result_valid;
    xif_result_t result;
  } xif_resp_t;

  // Decoder to ALU stage 1 contents
  typedef struct packed {
    xif_op_e                 op;
    logic [`XIF_ID_BITS-1:0] id;
    xif_rs_t                 rs;
  } xif_exec_t;

endpackage

// File: hw/xif_settings.svh
/*
  Extension interface widths
  Shared sizes for operands, transaction ids and operand count
*/
`ifndef XIF_SETTINGS_SVH
`define XIF_SETTINGS_SVH

// Operand and result width
`define XIF_XLEN 32

// Transaction id width
`define XIF_ID_BITS 3

// Source operands carried by each issue request
`define XIF_NUM_RS 3

`endif

// File: hw/xif_subsystem.sv
/*
  Extension interface subsystem
  Core functional unit joined to the decoder and ALU coprocessor
*/
`timescale 1ns/1ps
`include "xif_settings.svh"

module xif_subsystem
  import xif_pkg::*;
  import core_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  fu_data_t                fu_data_i,
  input  priv_lvl_e               priv_lvl_i,
  input  logic                    x_valid_i,
  output logic                    x_ready_o,
  input  logic [31:0]             x_off_instr_i,
  output logic [`XIF_ID_BITS-1:0] x_trans_id_o,
  output logic [`XIF_XLEN-1:0]    x_result_o,
  output logic                    x_we_o,
  output logic                    x_valid_o,
  output exception_t              x_exception_o
);

  xif_req_t    xif_req;
  xif_resp_t   xif_resp;
  xif_exec_t   exec;
  logic        exec_valid;
  logic        alu_ready;
  logic        issue_ready;
  logic        issue_accept;
  logic        result_valid;
  xif_result_t result;

  assign xif_resp = '{issue_ready:  issue_ready,
                      issue_accept: issue_accept,
                      result_valid: result_valid,
                      result:       result};

  xif_fu u_fu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fu_data_i     (fu_data_i),
    .priv_lvl_i    (priv_lvl_i),
    .x_valid_i     (x_valid_i),
    .x_ready_o     (x_ready_o),
    .x_off_instr_i (x_off_instr_i),
    .x_trans_id_o  (x_trans_id_o),
    .x_result_o    (x_result_o),
    .x_we_o        (x_we_o),
    .x_valid_o     (x_valid_o),
    .x_exception_o (x_exception_o),
    .xif_req_o     (xif_req),
    .xif_resp_i    (xif_resp)
  );

  xif_decoder u_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .xif_req_i      (xif_req),
    .alu_ready_i    (alu_ready),
    .issue_ready_o  (issue_ready),
    .issue_accept_o (issue_accept),
    .exec_o         (exec),
    .exec_valid_o   (exec_valid)
  );

  xif_alu u_alu (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .exec_i         (exec),
    .exec_valid_i   (exec_valid),
    .result_ready_i (xif_req.result_ready),
    .alu_ready_o    (alu_ready),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

endmodule

// File: src.f
+incdir+hw
hw/xif_pkg.sv
hw/core_pkg.sv
hw/xif_fu.sv
hw/xif_decoder.sv
hw/xif_alu.sv
hw/xif_subsystem.sv
tb/xif_assertions.sv
tb/xif_tb.sv

// File: tb/xif_assertions.sv
/*
  Extension interface timing checks
  Concurrent assertions bound into the core functional unit
*/
`timescale 1ns/1ps

module xif_assertions
  import xif_pkg::*;
  import core_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       x_valid_i,
  input logic       x_ready_i,
  input logic       x_we_i,
  input exception_t x_exception_i,
  input logic       pending_i,
  input xif_req_t   req_i,
  input xif_resp_t  resp_i
);

  int unsigned error_count = 0;

  // No writeback while in reset or on the first edge after it
  a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !x_valid_i)
    else begin
      $error("writeback valid during reset");
      error_count = error_count + 1;
    end

  a_no_valid_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !x_valid_i)
    else begin
      $error("writeback valid right after reset");
      error_count = error_count + 1;
    end

  // Accepted issue reaches ALU stage 2 two cycles later
  a_accept_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.issue_valid && resp_i.issue_ready && resp_i.issue_accept) |-> ##2
    resp_i.result_valid)
    else begin
      $error("accepted issue without result two cycles later");
      error_count = error_count + 1;
    end

  // A reject that meets a result is held, and issue stays closed meanwhile
  a_ready_low_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.issue_valid && resp_i.issue_ready && !resp_i.issue_accept &&
     resp_i.result_valid) |=> (pending_i && !x_ready_i))
    else begin
      $error("reject behind a result not held with issue ready low");
      error_count = error_count + 1;
    end

  a_no_write_on_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (x_valid_i && x_exception_i.valid) |-> !x_we_i)
    else begin
      $error("register write together with an exception");
      error_count = error_count + 1;
    end

endmodule

bind xif_fu xif_assertions u_assertions (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .x_valid_i     (x_valid_o),
  .x_ready_i     (x_ready_o),
  .x_we_i        (x_we_o),
  .x_exception_i (x_exception_o),
  .pending_i     (illegal_q),
  .req_i         (xif_req_o),
  .resp_i        (xif_resp_i)
);

// File: tb/xif_tb.sv
/*
  Testbench for the extension interface subsystem
  Directed issue sequences checked against a model of the custom-0
  instructions, with writebacks compared in order of arrival
*/
`timescale 1ns/1ps
`include "xif_settings.svh"

module xif_tb
  import xif_pkg::*;
  import core_pkg::*;
;

  localparam int NUM_ISSUES      = 14;
  // Ten cycles per issue, plus reset and drain time
  localparam int WATCHDOG_CYCLES = NUM_ISSUES * 10 + 100;
  localparam logic [6:0] CUSTOM0 = 7'h0b;

  typedef struct packed {
    logic [`XIF_ID_BITS-1:0] id;
    logic [`XIF_XLEN-1:0]    data;
    logic                    we;
    logic                    exc;
    logic [`XIF_XLEN-1:0]    cause;
    logic [`XIF_XLEN-1:0]    tval;
    logic                    rejected;
    logic [31:0]             due;
  } expected_t;

  logic                    clk_i;
  logic                    rst_ni;
  fu_data_t                fu_data_i;
  priv_lvl_e               priv_lvl_i;
  logic                    x_valid_i;
  logic                    x_ready_o;
  logic [31:0]             x_off_instr_i;
  logic [`XIF_ID_BITS-1:0] x_trans_id_o;
  logic [`XIF_XLEN-1:0]    x_result_o;
  logic                    x_we_o;
  logic                    x_valid_o;
  exception_t              x_exception_o;

  integer      seed = 32'h7f37_08fc;
  int unsigned cyc  = 0;
  expected_t   exp_q[$];
  bit          busy_cycle[int unsigned];

  xif_subsystem u_xif_subsystem (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  function automatic xif_op_e decode_op(input logic [31:0] instr);
    if (instr[6:0] != CUSTOM0 || instr[31:25] != 7'd0) begin
      return OP_NONE;
    end
    case (instr[14:12])
      3'd0:    return OP_XADD3;
      3'd1:    return OP_XMULLO;
      3'd2:    return OP_XMAXU;
      3'd3:    return OP_XBOUND;
      default: return OP_NONE;
    endcase
  endfunction

  function automatic expected_t model_writeback(input logic [31:0] instr,
      input priv_lvl_e mode, input logic [`XIF_ID_BITS-1:0] id,
      input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] rs3);
    expected_t   rec;
    xif_op_e     op;
    logic [63:0] prod;
    rec    = '0;
    rec.id = id;
    op     = decode_op(instr);
    if (op == OP_NONE || (op == OP_XMULLO && mode == PRIV_U)) begin
      rec.rejected = 1'b1;
      rec.exc      = 1'b1;
      rec.cause    = 32'(CAUSE_ILLEGAL_INSTR);
      rec.tval     = instr;
    end else begin
      rec.we = 1'b1;
      case (op)
        OP_XADD3:  rec.data = rs1 + rs2 + rs3;
        OP_XMULLO: begin
          prod     = 64'(rs1) * 64'(rs2);
          rec.data = prod[31:0];
        end
        OP_XMAXU:  rec.data = (rs1 >= rs2) ? rs1 : rs2;
        default: begin
          if (rs1 <= rs2) begin
            rec.data = rs1;
          end else begin
            rec.we    = 1'b0;
            rec.exc   = 1'b1;
            rec.cause = 32'(CAUSE_XBOUND);
          end
        end
      endcase
    end
    return rec;
  endfunction

  // Results own their cycle, a reject takes the first free one
  task automatic push_expected(input expected_t rec, input int unsigned hs);
    int unsigned due;
    int          idx;
    due = hs;
    if (!rec.rejected) begin
      due             = hs + 2;
      busy_cycle[due] = 1'b1;
    end else begin
      while (busy_cycle.exists(due)) due++;
    end
    rec.due = due;
    idx     = 0;
    while (idx < exp_q.size() && exp_q[idx].due < due) idx++;
    exp_q.insert(idx, rec);
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic issue_instr(input logic [31:0] instr, input priv_lvl_e mode,
      input logic [`XIF_ID_BITS-1:0] id, input logic [31:0] a,
      input logic [31:0] b, input logic [31:0] c);
    expected_t rec;
    bit        done;
    rec                 = model_writeback(instr, mode, id, a, b, c);
    done                = 1'b0;
    x_valid_i           = 1'b1;
    x_off_instr_i       = instr;
    priv_lvl_i          = mode;
    fu_data_i.trans_id  = id;
    fu_data_i.operand_a = a;
    fu_data_i.operand_b = b;
    fu_data_i.imm       = c;
    while (!done) begin
      // x_ready_o comes from registers only
      #4;
      if (x_ready_o) begin
        push_expected(rec, cyc);
        done = 1'b1;
      end
      @(posedge clk_i);
      #1;
    end
    x_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
  endtask

  task automatic compare_writeback();
    expected_t rec;
    if (exp_q.size() == 0) begin
      $display("Unexpected writeback with id 0x%0h", x_trans_id_o);
      stop_run();
    end else begin
      rec = exp_q.pop_front();
      check_value("x_trans_id_o", 32'(x_trans_id_o), 32'(rec.id));
      check_value("x_we_o", 32'(x_we_o), 32'(rec.we));
      check_value("x_exception_o.valid", 32'(x_exception_o.valid), 32'(rec.exc));
      check_value("x_exception_o.cause", x_exception_o.cause, rec.cause);
      if (!rec.exc || rec.rejected) check_value("x_result_o", x_result_o, rec.data);
      if (rec.rejected) check_value("x_exception_o.tval", x_exception_o.tval, rec.tval);
      if (!rec.rejected) check_value("x_valid_o cycle", cyc, rec.due);
    end
  endtask

  function automatic logic [31:0] make_instr(input logic [6:0] funct7,
      input logic [2:0] funct3, input logic [6:0] opcode);
    return {funct7, 5'd7, 5'd6, funct3, 5'd5, opcode};
  endfunction

  task automatic test_single_add();
    @(negedge clk_i);
    check_value("x_valid_o", 32'(x_valid_o), 32'd0);
    check_value("x_ready_o", 32'(x_ready_o), 32'd1);
    @(posedge clk_i);
    #1;
    issue_instr(make_instr(7'd0, 3'd0, CUSTOM0), PRIV_M, 3'd1, 32'h1234_5678,
                32'h0000_1111, 32'hf000_0001);
    wait_drain();
  endtask

  task automatic test_back_to_back();
    issue_instr(make_instr(7'd0, 3'd1, CUSTOM0), PRIV_M, 3'd2, $random(seed),
                $random(seed), $random(seed));
    issue_instr(make_instr(7'd0, 3'd2, CUSTOM0), PRIV_S, 3'd3, $random(seed),
                $random(seed), $random(seed));
    issue_instr(make_instr(7'd0, 3'd0, CUSTOM0), PRIV_U, 3'd4, $random(seed),
                $random(seed), $random(seed));
    wait_drain();
  endtask

  task automatic test_bound();
    logic [31:0] low;
    low = 32'($random(seed)) >> 1;
    issue_instr(make_instr(7'd0, 3'd3, CUSTOM0), PRIV_M, 3'd5, low, low + 5, 32'd0);
    issue_instr(make_instr(7'd0, 3'd3, CUSTOM0), PRIV_M, 3'd6, low, low, 32'd0);
    issue_instr(make_instr(7'd0, 3'd3, CUSTOM0), PRIV_M, 3'd7, low + 9, low, 32'd0);
    wait_drain();
  endtask

  task automatic test_illegal();
    issue_instr(make_instr(7'd0, 3'd5, CUSTOM0), PRIV_M, 3'd0, 32'd1, 32'd2, 32'd3);
    wait_drain();
    issue_instr(make_instr(7'd0, 3'd0, 7'h33), PRIV_M, 3'd1, 32'd4, 32'd5, 32'd6);
    wait_drain();
    issue_instr(make_instr(7'd0, 3'd1, CUSTOM0), PRIV_U, 3'd2, 32'd7, 32'd8, 32'd9);
    wait_drain();
  endtask

  // Reject lands on the cycle of the first result, report must wait
  task automatic test_reject_behind_result();
    issue_instr(make_instr(7'd0, 3'd0, CUSTOM0), PRIV_M, 3'd4, $random(seed),
                $random(seed), $random(seed));
    issue_instr(make_instr(7'd0, 3'd2, CUSTOM0), PRIV_M, 3'd5, $random(seed),
                $random(seed), $random(seed));
    issue_instr(make_instr(7'd0, 3'd6, CUSTOM0), PRIV_M, 3'd6, 32'd0, 32'd0, 32'd0);
    issue_instr(make_instr(7'd0, 3'd0, CUSTOM0), PRIV_M, 3'd7, $random(seed),
                $random(seed), $random(seed));
    wait_drain();
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && x_valid_o) compare_writeback();
    end
  end

  initial begin
    wait (u_xif_subsystem.u_fu.u_assertions.error_count != 0);
    $display("An interface timing assertion failed");
    stop_run();
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    stop_run();
  end

  initial begin
    rst_ni        = 1'b0;
    x_valid_i     = 1'b0;
    fu_data_i     = '0;
    priv_lvl_i    = PRIV_M;
    x_off_instr_i = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_single_add();
    test_back_to_back();
    test_bound();
    test_illegal();
    test_reject_behind_result();
    if (exp_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Expected writebacks still outstanding at end of run");
      stop_run();
    end
  end

endmodule
